// File: src/moxie_isa_pkg.sv
// command word encoding for the register-access core
// one 16-bit word per command, opcode in the top nibble
// opcodes 12 to 15 are not decoded and behave as nop
// immediate form is used only by ldi and inc
`default_nettype none

package moxie_isa_pkg;

  // register file geometry
  localparam int NUM_REGS = 16;

  typedef logic [3:0] reg_idx_t;

  // fixed roles of the first two registers
  localparam reg_idx_t FP_IDX = 4'd0;
  localparam reg_idx_t SP_IDX = 4'd1;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_MOV  = 4'd1,
    OP_ADD  = 4'd2,
    OP_SUB  = 4'd3,
    OP_AND  = 4'd4,
    OP_OR   = 4'd5,
    OP_XOR  = 4'd6,
    OP_LDI  = 4'd7,
    OP_INC  = 4'd8,
    OP_PUSH = 4'd9,
    OP_POP  = 4'd10,
    OP_OUT  = 4'd11
  } opcode_e;

  // register form: two register operands
  typedef struct packed {
    opcode_e    opcode;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic [3:0] unused;
  } cmd_reg_t;

  // immediate form: ra plus an 8-bit immediate
  typedef struct packed {
    opcode_e    opcode;
    reg_idx_t   ra;
    logic [7:0] imm;
  } cmd_imm_t;

  typedef union packed {
    cmd_reg_t rform;
    cmd_imm_t iform;
  } cmd_word_u;

  function automatic logic cmd_is_imm(opcode_e op);
    return (op == OP_LDI) || (op == OP_INC);
  endfunction

endpackage

`default_nettype wire

// File: src/moxie_dp_pkg.sv
// datapath records shared by the issue stage and the units
// stack pointer is a byte address, word aligned
// only sp bits 7..2 index the stack memory, higher bits are ignored
`default_nettype none

package moxie_dp_pkg;

  import moxie_isa_pkg::*;

  // data word
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // internal stack memory
  localparam int STACK_WORDS = 64;
  localparam int STACK_IDX_W = $clog2(STACK_WORDS);

  // record handed from issue to exactly one unit
  typedef struct packed {
    logic       valid;
    opcode_e    opcode;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic [7:0] imm;
  } issue_t;

  // register file write request
  typedef struct packed {
    logic     valid;
    reg_idx_t idx;
    word_t    data;
  } wb_req_t;

endpackage

`default_nettype wire

// File: src/moxie_regfile.sv
// 16 x 32 register file, two write ports and two registered read ports
// reads return the contents from before a same-edge write, no bypass
// write port 1 wins on an index clash, which issue never lets happen
// fp and sp taps are continuous views of entries 0 and 1
`timescale 1ns/1ps
`default_nettype none

module moxie_regfile
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire wb_req_t  wr0_i,
  input  wire wb_req_t  wr1_i,
  input  wire reg_idx_t rd_idx0_i,
  input  wire reg_idx_t rd_idx1_i,
  output word_t         rd_data0_o,
  output word_t         rd_data1_o,
  output word_t         fp_o,
  output word_t         sp_o
);

  word_t regs [NUM_REGS];

  // architectural state, cleared on reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wr0_i.valid) begin
        regs[wr0_i.idx] <= wr0_i.data;
      end
      // later assignment gives port 1 priority
      if (wr1_i.valid) begin
        regs[wr1_i.idx] <= wr1_i.data;
      end
    end
  end

  // operand registers
  always_ff @(posedge clk_i) begin
    rd_data0_o <= regs[rd_idx0_i];
    rd_data1_o <= regs[rd_idx1_i];
  end

  assign fp_o = regs[FP_IDX];
  assign sp_o = regs[SP_IDX];

endmodule

`default_nettype wire

// File: src/moxie_issue.sv
// issue stage: decode, scoreboard and stall
// a command is accepted when cmd_valid_i is high and stall_o is low
// read indices come straight from cmd_i so operands land one cycle later
// pending bits clear only on the write edge, so the read after that edge sees new data
`timescale 1ns/1ps
`default_nettype none

module moxie_issue
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  input  wire logic      cmd_valid_i,
  input  wire cmd_word_u cmd_i,
  input  wire logic      alu_hold_i,
  input  wire wb_req_t   wr0_i,
  input  wire wb_req_t   wr1_i,
  output logic           stall_o,
  output issue_t         alu_issue_o,
  output issue_t         stack_issue_o,
  output reg_idx_t       rd_idx0_o,
  output reg_idx_t       rd_idx1_o
);

  logic [NUM_REGS-1:0] pending_q;
  logic [NUM_REGS-1:0] rd_mask;
  logic [NUM_REGS-1:0] wr_mask;
  logic [NUM_REGS-1:0] clr_mask;
  logic                is_imm;
  logic                is_alu;
  logic                is_stack;
  logic                accept;
  issue_t              dec;

  assign is_imm = cmd_is_imm(cmd_i.rform.opcode);

  // both forms share opcode and ra, rb and imm depend on the form
  always_comb begin
    dec.valid  = 1'b1;
    dec.opcode = cmd_i.rform.opcode;
    dec.ra     = cmd_i.rform.ra;
    dec.rb     = is_imm ? FP_IDX : cmd_i.rform.rb;
    dec.imm    = is_imm ? cmd_i.iform.imm : 8'h00;
  end

  // unit selection plus read and write sets
  always_comb begin
    is_alu   = 1'b0;
    is_stack = 1'b0;
    rd_mask  = '0;
    wr_mask  = '0;
    case (dec.opcode)
      OP_MOV: begin
        is_alu          = 1'b1;
        rd_mask[dec.rb] = 1'b1;
        wr_mask[dec.ra] = 1'b1;
      end
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        is_alu          = 1'b1;
        rd_mask[dec.ra] = 1'b1;
        rd_mask[dec.rb] = 1'b1;
        wr_mask[dec.ra] = 1'b1;
      end
      OP_LDI: begin
        is_alu          = 1'b1;
        wr_mask[dec.ra] = 1'b1;
      end
      OP_INC: begin
        is_alu          = 1'b1;
        rd_mask[dec.ra] = 1'b1;
        wr_mask[dec.ra] = 1'b1;
      end
      OP_OUT: begin
        is_alu          = 1'b1;
        rd_mask[dec.ra] = 1'b1;
      end
      OP_PUSH: begin
        is_stack        = 1'b1;
        rd_mask[dec.ra] = 1'b1;
        rd_mask[SP_IDX] = 1'b1;
        wr_mask[SP_IDX] = 1'b1;
      end
      OP_POP: begin
        is_stack        = 1'b1;
        rd_mask[SP_IDX] = 1'b1;
        wr_mask[dec.ra] = 1'b1;
        wr_mask[SP_IDX] = 1'b1;
      end
      // nop and the undecoded codes touch nothing
      default: ;
    endcase
  end

  // hazard on any touched register, or the alu still holds a refused write
  assign stall_o   = cmd_valid_i && (|((rd_mask | wr_mask) & pending_q) || alu_hold_i);
  assign accept    = cmd_valid_i && !stall_o;
  assign rd_idx0_o = dec.ra;
  assign rd_idx1_o = dec.rb;

  always_comb begin
    clr_mask = '0;
    if (wr0_i.valid) clr_mask[wr0_i.idx] = 1'b1;
    if (wr1_i.valid) clr_mask[wr1_i.idx] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q     <= '0;
      alu_issue_o   <= '0;
      stack_issue_o <= '0;
    end else begin
      // set wins, though issue never sets a bit that is being cleared
      pending_q           <= (pending_q & ~clr_mask) | (accept ? wr_mask : '0);
      alu_issue_o         <= dec;
      alu_issue_o.valid   <= accept && is_alu;
      stack_issue_o       <= dec;
      stack_issue_o.valid <= accept && is_stack;
    end
  end

endmodule

`default_nettype wire

// File: src/moxie_alu_unit.sv
// alu unit, works in the cycle after issue on registered operands
// opa is ra's value, opb is rb's value
// a refused write sits in a one-entry hold and asks again each cycle
// hold_o is high in the refused cycle too, so issue stalls right away
`timescale 1ns/1ps
`default_nettype none

module moxie_alu_unit
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   arst_n_i,
  input  wire issue_t issue_i,
  input  wire word_t  opa_i,
  input  wire word_t  opb_i,
  input  wire logic   gnt_i,
  output wb_req_t     wb_req_o,
  output logic        hold_o,
  output word_t       result_o,
  output logic        result_valid_o
);

  word_t   result;
  logic    writes;
  wb_req_t fresh_req;
  wb_req_t hold_q;
  logic    hold_valid_q;

  always_comb begin
    result = opa_i;
    writes = 1'b1;
    case (issue_i.opcode)
      OP_MOV: result = opb_i;
      OP_ADD: result = opa_i + opb_i;
      OP_SUB: result = opa_i - opb_i;
      OP_AND: result = opa_i & opb_i;
      OP_OR:  result = opa_i | opb_i;
      OP_XOR: result = opa_i ^ opb_i;
      // immediate zero-extended
      OP_LDI: result = word_t'(issue_i.imm);
      OP_INC: result = opa_i + word_t'(issue_i.imm);
      // out and the rest write nothing
      default: writes = 1'b0;
    endcase
  end

  assign fresh_req = '{valid: issue_i.valid && writes, idx: issue_i.ra, data: result};

  // a held request goes first, issue keeps new ones out meanwhile
  assign wb_req_o = hold_valid_q ? hold_q : fresh_req;
  assign hold_o   = wb_req_o.valid && !gnt_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_valid_q <= 1'b0;
    end else begin
      hold_valid_q <= hold_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_o) begin
      hold_q <= wb_req_o;
    end
  end

  // out shows ra for exactly the issue cycle
  assign result_o       = opa_i;
  assign result_valid_o = issue_i.valid && (issue_i.opcode == OP_OUT);

endmodule

`default_nettype wire

// File: src/moxie_stack_unit.sv
// stack unit with a private 64-word stack memory
// push: sp -= 4 and store ra at the new sp, both in cycle 1
// pop: read at sp in cycle 1, write ra and sp += 4 in cycle 2
// sp above 8 bits wraps in the memory, pop into sp is undefined
`timescale 1ns/1ps
`default_nettype none

module moxie_stack_unit
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   arst_n_i,
  input  wire issue_t issue_i,
  input  wire word_t  opa_i,
  input  wire word_t  sp_i,
  input  wire logic   gnt_i,
  output wb_req_t     wb_req_o,
  output wb_req_t     sp_wr_o
);

  word_t                  stack_mem [STACK_WORDS];
  word_t                  sp_dec;
  word_t                  sp_inc;
  logic                   push_s1;
  logic                   pop_s1;
  logic [STACK_IDX_W-1:0] push_idx;
  logic [STACK_IDX_W-1:0] pop_idx;
  logic                   pop_valid_q;
  reg_idx_t               pop_ra_q;
  word_t                  pop_data_q;

  assign push_s1 = issue_i.valid && (issue_i.opcode == OP_PUSH);
  assign pop_s1  = issue_i.valid && (issue_i.opcode == OP_POP);

  assign sp_dec   = sp_i - word_t'(4);
  assign sp_inc   = sp_i + word_t'(4);
  // word index from the byte address
  assign push_idx = sp_dec[STACK_IDX_W+1:2];
  assign pop_idx  = sp_i[STACK_IDX_W+1:2];

  always_ff @(posedge clk_i) begin
    if (push_s1) begin
      stack_mem[push_idx] <= opa_i;
    end
    if (pop_s1) begin
      pop_data_q <= stack_mem[pop_idx];
      pop_ra_q   <= issue_i.ra;
    end
  end

  // pop write-back stays up until granted
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pop_valid_q <= 1'b0;
    end else begin
      pop_valid_q <= pop_s1 || (pop_valid_q && !gnt_i);
    end
  end

  assign wb_req_o = '{valid: pop_valid_q, idx: pop_ra_q, data: pop_data_q};

  // sp port is private, push and pop never overlap since sp is pending
  always_comb begin
    sp_wr_o = '{valid: 1'b0, idx: SP_IDX, data: sp_dec};
    if (push_s1) begin
      sp_wr_o.valid = 1'b1;
    end else if (pop_valid_q && gnt_i) begin
      // sp moves together with the popped register
      sp_wr_o.valid = 1'b1;
      sp_wr_o.data  = sp_inc;
    end
  end

endmodule

`default_nettype wire

// File: src/moxie_wb_arbiter.sv
// write port 0 arbiter, stack unit over alu unit
// purely combinational, the loser keeps its own request
`timescale 1ns/1ps
`default_nettype none

module moxie_wb_arbiter
  import moxie_dp_pkg::*;
(
  input  wire wb_req_t stack_req_i,
  input  wire wb_req_t alu_req_i,
  output logic         stack_gnt_o,
  output logic         alu_gnt_o,
  output wb_req_t      wr_o
);

  // fixed priority
  assign stack_gnt_o = stack_req_i.valid;
  assign alu_gnt_o   = alu_req_i.valid && !stack_req_i.valid;

  // winner drives the port, idle when nobody asks
  always_comb begin
    if (stack_gnt_o) begin
      wr_o = stack_req_i;
    end else begin
      wr_o       = alu_req_i;
      wr_o.valid = alu_gnt_o;
    end
  end

endmodule

`default_nettype wire

// File: src/moxie_regs_top.sv
// register-access core top level
// source must hold cmd_i while stall_o is high
// latency varies with write-back collisions, use out or the taps to observe
`timescale 1ns/1ps
`default_nettype none

module moxie_regs_top
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      arst_n_i,
  input  wire logic      cmd_valid_i,
  input  wire cmd_word_u cmd_i,
  output logic           stall_o,
  output word_t          result_o,
  output logic           result_valid_o,
  output word_t          fp_o,
  output word_t          sp_o
);

  issue_t   alu_issue;
  issue_t   stack_issue;
  reg_idx_t rd_idx0;
  reg_idx_t rd_idx1;
  word_t    rd_data0;
  word_t    rd_data1;
  wb_req_t  alu_req;
  wb_req_t  stack_req;
  wb_req_t  wr0;
  wb_req_t  wr1;
  logic     alu_gnt;
  logic     stack_gnt;
  logic     alu_hold;

  moxie_issue u_issue (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .alu_hold_i    (alu_hold),
    .wr0_i         (wr0),
    .wr1_i         (wr1),
    .stall_o       (stall_o),
    .alu_issue_o   (alu_issue),
    .stack_issue_o (stack_issue),
    .rd_idx0_o     (rd_idx0),
    .rd_idx1_o     (rd_idx1)
  );

  moxie_regfile u_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr0_i      (wr0),
    .wr1_i      (wr1),
    .rd_idx0_i  (rd_idx0),
    .rd_idx1_i  (rd_idx1),
    .rd_data0_o (rd_data0),
    .rd_data1_o (rd_data1),
    .fp_o       (fp_o),
    .sp_o       (sp_o)
  );

  moxie_alu_unit u_alu (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .issue_i        (alu_issue),
    .opa_i          (rd_data0),
    .opb_i          (rd_data1),
    .gnt_i          (alu_gnt),
    .wb_req_o       (alu_req),
    .hold_o         (alu_hold),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

  // stack operand is ra through read port 0
  moxie_stack_unit u_stack (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .issue_i  (stack_issue),
    .opa_i    (rd_data0),
    .sp_i     (sp_o),
    .gnt_i    (stack_gnt),
    .wb_req_o (stack_req),
    .sp_wr_o  (wr1)
  );

  moxie_wb_arbiter u_wb_arb (
    .stack_req_i (stack_req),
    .alu_req_i   (alu_req),
    .stack_gnt_o (stack_gnt),
    .alu_gnt_o   (alu_gnt),
    .wr_o        (wr0)
  );

endmodule

`default_nettype wire

// File: verification/moxie_regs_assertions.sv
// concurrent checks on moxie_regs_top, attached with bind
// sampled on the rising clock, reset gates all but the post-reset check
`timescale 1ns/1ps
`default_nettype none

module moxie_regs_assertions
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
(
  input wire logic      clk_i,
  input wire logic      arst_n_i,
  input wire logic      cmd_valid_i,
  input wire cmd_word_u cmd_i,
  input wire logic      stall_i,
  input wire logic      result_valid_i,
  input wire wb_req_t   alu_req_i,
  input wire logic      alu_gnt_i,
  input wire logic      stack_gnt_i,
  input wire wb_req_t   wr0_i,
  input wire wb_req_t   wr1_i
);

  logic out_accept;

  // an out command taken at the coming edge
  assign out_accept = cmd_valid_i && !stall_i && (cmd_i.rform.opcode == OP_OUT);

  // a write that lost port 0 to the stack unit comes back unchanged and wins
  a_collision_retry: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (alu_req_i.valid && stack_gnt_i) |=> (alu_gnt_i && (alu_req_i == $past(alu_req_i)))
  ) else $error("alu write refused at a collision was not granted unchanged next cycle");

  // two pulses in a row need two outs accepted back to back
  a_out_pulse: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (result_valid_i && $past(result_valid_i)) |-> ($past(out_accept) && $past(out_accept, 2))
  ) else $error("result_valid_o high twice without back-to-back out commands");

  a_stall_after_reset: assert property (
    @(posedge clk_i)
    $rose(arst_n_i) |-> !stall_i
  ) else $error("stall_o high in the first cycle after reset");

  // sp belongs to port 1 while the stack unit moves it
  a_sp_port: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !(wr0_i.valid && (wr0_i.idx == SP_IDX) && wr1_i.valid)
  ) else $error("write port 0 targets sp while port 1 writes");

endmodule

bind moxie_regs_top moxie_regs_assertions u_assertions (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .cmd_valid_i    (cmd_valid_i),
  .cmd_i          (cmd_i),
  .stall_i        (stall_o),
  .result_valid_i (result_valid_o),
  .alu_req_i      (alu_req),
  .alu_gnt_i      (alu_gnt),
  .stack_gnt_i    (stack_gnt),
  .wr0_i          (wr0),
  .wr1_i          (wr1)
);

`default_nettype wire

// File: verification/moxie_regs_tb.sv
// random-stimulus testbench for moxie_regs_top against an architectural model
// commands are held while stall_o is high, each wait loop has its own timeout
// sp is set to 0xc0 first so push and pop stay inside the low 8 bits
// pop never targets r1 and push never stores r1
`timescale 1ns/1ps
`default_nettype none

module moxie_regs_tb
  import moxie_isa_pkg::*, moxie_dp_pkg::*;
();

  localparam int unsigned SEED       = 32'h196b_5e7b;
  localparam int          WAIT_LIMIT = 64;
  localparam int          MAX_DEPTH  = 40;

  logic      clk;
  logic      arst_n;
  logic      cmd_valid;
  cmd_word_u cmd;
  logic      stall;
  word_t     result;
  logic      result_valid;
  word_t     fp;
  word_t     sp;

  // architectural model, updated in program order at acceptance
  word_t model_regs [NUM_REGS];
  word_t model_stack [STACK_WORDS];
  word_t out_queue [$];
  int    depth;

  int    cyc = 0;
  int    last_out_cyc;
  int    errors;
  int    checks;
  bit    saw_stall;
  bit    timed_out;
  string test_name;

  moxie_regs_top u_dut (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_i          (cmd),
    .stall_o        (stall),
    .result_o       (result),
    .result_valid_o (result_valid),
    .fp_o           (fp),
    .sp_o           (sp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  function automatic cmd_word_u reg_cmd(opcode_e op, reg_idx_t ra, reg_idx_t rb);
    cmd_word_u c;
    c = {op, ra, rb, 4'h0};
    return c;
  endfunction

  function automatic cmd_word_u imm_cmd(opcode_e op, reg_idx_t ra, logic [7:0] imm);
    cmd_word_u c;
    c = {op, ra, imm};
    return c;
  endfunction

  // general purpose registers only
  function automatic reg_idx_t random_reg();
    return reg_idx_t'(2 + $urandom_range(13, 0));
  endfunction

  function automatic cmd_word_u random_alu_cmd();
    int unsigned sel;
    reg_idx_t    ra;
    reg_idx_t    rb;
    sel = $urandom_range(7, 0);
    ra  = random_reg();
    rb  = random_reg();
    case (sel)
      0: return reg_cmd(OP_MOV, ra, rb);
      1: return reg_cmd(OP_ADD, ra, rb);
      2: return reg_cmd(OP_SUB, ra, rb);
      3: return reg_cmd(OP_AND, ra, rb);
      4: return reg_cmd(OP_OR, ra, rb);
      5: return reg_cmd(OP_XOR, ra, rb);
      6: return imm_cmd(OP_LDI, ra, 8'($urandom()));
      default: return imm_cmd(OP_INC, ra, 8'($urandom()));
    endcase
  endfunction

  // raw field positions: op 15..12, ra 11..8, rb 7..4, imm 7..0
  function automatic void update_model(cmd_word_u c);
    logic [3:0] op;
    reg_idx_t   ra;
    reg_idx_t   rb;
    logic [7:0] imm;
    word_t      sp_next;
    op  = c[15:12];
    ra  = c[11:8];
    rb  = c[7:4];
    imm = c[7:0];
    case (op)
      OP_MOV: model_regs[ra] = model_regs[rb];
      OP_ADD: model_regs[ra] = model_regs[ra] + model_regs[rb];
      OP_SUB: model_regs[ra] = model_regs[ra] - model_regs[rb];
      OP_AND: model_regs[ra] = model_regs[ra] & model_regs[rb];
      OP_OR:  model_regs[ra] = model_regs[ra] | model_regs[rb];
      OP_XOR: model_regs[ra] = model_regs[ra] ^ model_regs[rb];
      OP_LDI: model_regs[ra] = {24'd0, imm};
      OP_INC: model_regs[ra] = model_regs[ra] + {24'd0, imm};
      OP_PUSH: begin
        // predecrement, word index from bits 7..2
        sp_next = model_regs[SP_IDX] - 32'd4;
        model_stack[sp_next[7:2]] = model_regs[ra];
        model_regs[SP_IDX] = sp_next;
      end
      OP_POP: begin
        model_regs[ra] = model_stack[model_regs[SP_IDX][7:2]];
        model_regs[SP_IDX] = model_regs[SP_IDX] + 32'd4;
      end
      OP_OUT: out_queue.push_back(model_regs[ra]);
      default: ;
    endcase
  endfunction

  // entered and left 1 ns after a rising edge
  task automatic send_cmd(input cmd_word_u c);
    int waited;
    waited = 0;
    if (!timed_out) begin
      cmd_valid = 1'b1;
      cmd = c;
      @(negedge clk);
      while (stall && !timed_out) begin
        saw_stall = 1'b1;
        if (waited == WAIT_LIMIT) begin
          $display("timeout: command %h held by stall_o for %0d cycles", c, WAIT_LIMIT);
          errors++;
          timed_out = 1'b1;
        end else begin
          waited++;
          @(negedge clk);
        end
      end
      @(posedge clk);
      #1;
      if (!timed_out) begin
        update_model(c);
        if (c[15:12] == OP_OUT) begin
          last_out_cyc = cyc;
        end
      end
      cmd_valid = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    cmd_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_outs_done();
    int waited;
    waited = 0;
    while (out_queue.size() != 0 && !timed_out) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout: %0d out results never appeared", out_queue.size());
        errors++;
        timed_out = 1'b1;
      end else begin
        waited++;
        @(posedge clk);
        #1;
      end
    end
  endtask

  // out r1 waits for every sp update, so the taps are settled afterwards
  task automatic verify_taps();
    send_cmd(reg_cmd(OP_OUT, SP_IDX, 4'd0));
    wait_outs_done();
    check_value({test_name, " sp tap"}, model_regs[SP_IDX], sp);
    check_value({test_name, " fp tap"}, model_regs[FP_IDX], fp);
  endtask

  // result_valid_o must follow an accepted out by exactly one cycle
  task automatic watch_outputs();
    forever begin
      @(negedge clk);
      check_value({test_name, " out timing"}, {31'd0, cyc == last_out_cyc},
                  {31'd0, result_valid});
      if (result_valid) begin
        if (out_queue.size() == 0) begin
          $display("result_valid_o pulsed with no out command outstanding");
          errors++;
        end else begin
          check_value({test_name, " out value"}, out_queue.pop_front(), result);
        end
      end
    end
  endtask

  task automatic finish_run();
    $display("moxie_regs_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  initial begin
    cmd_word_u   c;
    reg_idx_t    ra;
    reg_idx_t    rb;
    int unsigned sel;
    void'($urandom(SEED));
    arst_n       = 1'b0;
    cmd_valid    = 1'b0;
    cmd          = '0;
    errors       = 0;
    checks       = 0;
    last_out_cyc = -1;
    saw_stall    = 1'b0;
    timed_out    = 1'b0;
    depth        = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < STACK_WORDS; i++) begin
      model_stack[i] = '0;
    end

    test_name = "reset";
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // a command already waits as reset goes away, the empty scoreboard takes it
    c         = reg_cmd(OP_ADD, 4'd2, 4'd3);
    cmd_valid = 1'b1;
    cmd       = c;
    @(negedge clk);
    check_value({test_name, " fp"}, 32'd0, fp);
    check_value({test_name, " sp"}, 32'd0, sp);
    check_value({test_name, " result_valid"}, 32'd0, {31'd0, result_valid});
    check_value({test_name, " stall"}, 32'd0, {31'd0, stall});
    @(posedge clk);
    #1;
    update_model(c);
    cmd_valid = 1'b0;
    fork
      watch_outputs();
    join_none

    // known contents and a stack pointer with headroom
    test_name = "init";
    for (int r = 2; r < NUM_REGS; r++) begin
      send_cmd(imm_cmd(OP_LDI, reg_idx_t'(r), 8'($urandom())));
    end
    send_cmd(imm_cmd(OP_LDI, SP_IDX, 8'hc0));
    verify_taps();

    test_name = "alu";
    for (int i = 0; i < 200; i++) begin
      c = random_alu_cmd();
      send_cmd(c);
      if ($urandom_range(1, 0) == 1) begin
        send_cmd(reg_cmd(OP_OUT, c.rform.ra, 4'd0));
      end
      if ($urandom_range(3, 0) == 0) begin
        idle_cycles(int'($urandom_range(3, 1)));
      end
    end

    test_name = "stack";
    for (int i = 0; i < 240; i++) begin
      sel = $urandom_range(9, 0);
      ra  = random_reg();
      if (depth == 0 || (sel < 3 && depth < MAX_DEPTH)) begin
        send_cmd(reg_cmd(OP_PUSH, ra, 4'd0));
        depth++;
      end else if (sel < 6 || depth >= MAX_DEPTH) begin
        send_cmd(reg_cmd(OP_POP, ra, 4'd0));
        depth--;
        // read the popped value back now and then
        if (sel[0]) begin
          send_cmd(reg_cmd(OP_OUT, ra, 4'd0));
        end
      end else if (sel < 7) begin
        send_cmd(random_alu_cmd());
      end else if (sel == 7) begin
        // alu write of sp between stack operations, value unchanged
        send_cmd(imm_cmd(OP_INC, SP_IDX, 8'd0));
      end else begin
        send_cmd(reg_cmd(OP_OUT, reg_idx_t'($urandom_range(15, 0)), 4'd0));
      end
      if (i % 30 == 29) begin
        verify_taps();
      end
    end

    test_name = "collision";
    for (int i = 0; i < 40; i++) begin
      ra = random_reg();
      rb = random_reg();
      if (rb == ra) begin
        rb = (ra == 4'd15) ? 4'd2 : ra + 4'd1;
      end
      if (depth == 0) begin
        send_cmd(reg_cmd(OP_PUSH, rb, 4'd0));
        depth++;
      end
      // pop, then an independent alu write that loses port 0 to it
      send_cmd(reg_cmd(OP_POP, ra, 4'd0));
      depth--;
      send_cmd(imm_cmd(OP_INC, rb, 8'($urandom())));
      // dependent chain on both fresh destinations
      send_cmd(reg_cmd(OP_ADD, ra, rb));
      send_cmd(reg_cmd(OP_OUT, ra, 4'd0));
      send_cmd(reg_cmd(OP_OUT, rb, 4'd0));
    end

    // whole register file through out
    test_name = "final";
    for (int r = 0; r < NUM_REGS; r++) begin
      send_cmd(reg_cmd(OP_OUT, reg_idx_t'(r), 4'd0));
    end
    wait_outs_done();
    verify_taps();
    if (!saw_stall) begin
      $display("stall_o was never seen high during the run");
      errors++;
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: moxie_regs.f
src/moxie_isa_pkg.sv
src/moxie_dp_pkg.sv
src/moxie_regfile.sv
src/moxie_issue.sv
src/moxie_alu_unit.sv
src/moxie_stack_unit.sv
src/moxie_wb_arbiter.sv
src/moxie_regs_top.sv
verification/moxie_regs_assertions.sv
verification/moxie_regs_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the moxie_regs testbench with verilator
cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module moxie_regs_tb \
  --Mdir "$build_dir" -o moxie_regs_sim \
  -f moxie_regs.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/moxie_regs_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the log decides pass or fail
if grep -qx "Test OK" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
